/* acq_top.f */
+incdir+include
hdl/acq_pkg.sv
hdl/acq_param_regs.sv
hdl/sequence_acquisition.sv
hdl/acq_status_monitor.sv
hdl/acq_top.sv
testbench/tb_clock_gen.sv
testbench/acq_top_chk.sv
testbench/tb_acq_top.sv

/* hdl/acq_param_regs.sv */
`timescale 1ns/1ns
`include "acq_cfg.svh"

module acq_param_regs (
  input  logic                    clk,
  input  logic                    reset_n,

  // register write port
  input  logic                    reg_wr_i,
  input  acq_pkg::reg_addr_t      reg_addr_i,
  input  acq_pkg::reg_data_t      reg_wdata_i,

  // sequence boundary from the sequencer
  input  logic                    seq_start_i,

  // active parameter set
  output acq_pkg::clk_count_t     precharge_count_o,
  output acq_pkg::seq_idx_t       seq_n_o,
  output acq_pkg::seq_entry_t     seq0_o,
  output acq_pkg::seq_entry_t     seq1_o,
  output acq_pkg::seq_entry_t     seq2_o,
  output acq_pkg::seq_entry_t     seq3_o
);

  // shadow set, written by the register port
  acq_pkg::clk_count_t  precharge_sh;
  acq_pkg::seq_idx_t    seq_n_sh;
  acq_pkg::seq_entry_t  seq_sh [4];

  // active set, only changes at a sequence boundary
  acq_pkg::clk_count_t  precharge_act;
  acq_pkg::seq_idx_t    seq_n_act;
  acq_pkg::seq_entry_t  seq_act [4];

  logic pending_q;
  logic wr_valid;
  logic commit;

  // addresses above the last entry are dropped
  assign wr_valid = reg_wr_i && (reg_addr_i <= `ACQ_ADDR_SEQ3);
  assign commit   = seq_start_i && pending_q;

  //////////////////////////////////////////////////
  // shadow registers and pending flag
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      precharge_sh <= `ACQ_PRECHARGE_DEFAULT;
      seq_n_sh     <= `ACQ_SEQ_N_DEFAULT;
      seq_sh[0]    <= `ACQ_SEQ0_DEFAULT;
      seq_sh[1]    <= `ACQ_SEQ1_DEFAULT;
      seq_sh[2]    <= `ACQ_SEQ0_DEFAULT;
      seq_sh[3]    <= `ACQ_SEQ1_DEFAULT;
      pending_q    <= 1'b0;
    end
    else
    begin
      if (wr_valid)
      begin
        case (reg_addr_i)
          `ACQ_ADDR_PRECHARGE: precharge_sh <= reg_wdata_i;
          `ACQ_ADDR_SEQ_N:     seq_n_sh     <= reg_wdata_i[1:0];
          `ACQ_ADDR_SEQ0:      seq_sh[0]    <= reg_wdata_i[5:0];
          `ACQ_ADDR_SEQ1:      seq_sh[1]    <= reg_wdata_i[5:0];
          `ACQ_ADDR_SEQ2:      seq_sh[2]    <= reg_wdata_i[5:0];
          default:             seq_sh[3]    <= reg_wdata_i[5:0];
        endcase
      end
      // a write landing on the commit cycle stays pending for the next sequence
      if (wr_valid)
        pending_q <= 1'b1;
      else if (commit)
        pending_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // active registers, copied as a whole set
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      precharge_act <= `ACQ_PRECHARGE_DEFAULT;
      seq_n_act     <= `ACQ_SEQ_N_DEFAULT;
      seq_act[0]    <= `ACQ_SEQ0_DEFAULT;
      seq_act[1]    <= `ACQ_SEQ1_DEFAULT;
      seq_act[2]    <= `ACQ_SEQ0_DEFAULT;
      seq_act[3]    <= `ACQ_SEQ1_DEFAULT;
    end
    else if (commit)
    begin
      precharge_act <= precharge_sh;
      seq_n_act     <= seq_n_sh;
      seq_act       <= seq_sh;
    end
  end

  // new values show through during the commit cycle itself,
  // so the boot step of the new sequence already sees them
  assign precharge_count_o = commit ? precharge_sh : precharge_act;
  assign seq_n_o           = commit ? seq_n_sh     : seq_n_act;
  assign seq0_o            = commit ? seq_sh[0]    : seq_act[0];
  assign seq1_o            = commit ? seq_sh[1]    : seq_act[1];
  assign seq2_o            = commit ? seq_sh[2]    : seq_act[2];
  assign seq3_o            = commit ? seq_sh[3]    : seq_act[3];

endmodule

/* hdl/acq_pkg.sv */
package acq_pkg;

  // settling time in clock cycles
  typedef logic [23:0] clk_count_t;

  // azmux select code
  typedef logic [3:0] azmux_t;

  // pre-charge switch, 0 is boot
  typedef logic [1:0] pc_sw_t;

  // one sequence entry, {pc[1:0], azmux[3:0]}
  typedef logic [5:0] seq_entry_t;

  // position within the sequence, also used for seq_n
  typedef logic [1:0] seq_idx_t;

  // {last completed index, last-of-sequence flag}
  typedef logic [2:0] status_t;

  // logic analyser vector
  typedef logic [7:0] monitor_t;

  // register port
  typedef logic [2:0] reg_addr_t;
  typedef logic [23:0] reg_data_t;

  // sequencer states
  typedef enum logic [2:0] {
    ST_START, ST_BOOT, ST_BOOT_WAIT, ST_AZ_SEL,
    ST_AZ_WAIT, ST_PC_SEL, ST_PC_WAIT, ST_MEASURE
  } acq_state_t;

endpackage

/* hdl/acq_status_monitor.sv */
`timescale 1ns/1ns
`include "acq_cfg.svh"

module acq_status_monitor (
  input  logic                    clk,
  input  logic                    reset_n,

  // completion event from the sequencer
  input  logic                    sample_done_i,
  input  acq_pkg::seq_idx_t       sample_done_idx_i,
  input  logic                    sample_last_i,

  // live control lines, for the monitor only
  input  acq_pkg::azmux_t         azmux_i,
  input  acq_pkg::pc_sw_t         pc_sw_i,
  input  logic                    adc_reset_n_i,
  input  logic                    adc_measure_valid_i,

  // status word, led and analyser vector
  output acq_pkg::status_t        status_o,
  output logic                    led_o,
  output acq_pkg::monitor_t       monitor_o
);

  //////////////////////////////////////////////////
  // status and led
  // status holds through the next measurement,
  // software reads it while the adc is busy again
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      status_o <= 3'b000;
      led_o    <= 1'b0;
    end
    else if (sample_done_i)
    begin
      status_o <= {sample_done_idx_i, sample_last_i};
      // one toggle per completed sequence
      if (sample_last_i)
        led_o <= ~led_o;
    end
  end

  //////////////////////////////////////////////////
  // monitor decode
  // one-hot flags for the common az pins
  assign monitor_o[0] = (azmux_i == `ACQ_S3);
  assign monitor_o[1] = (azmux_i == `ACQ_S7);
  assign monitor_o[2] = (azmux_i == `ACQ_S1);
  assign monitor_o[3] = (azmux_i == `ACQ_S8);

  // pc switch as is
  assign monitor_o[5:4] = pc_sw_i;

  // adc run window and its end marker
  assign monitor_o[6] = adc_reset_n_i;
  assign monitor_o[7] = adc_measure_valid_i;

endmodule

/* hdl/acq_top.sv */
`timescale 1ns/1ns

module acq_top (
  input  logic                    clk,
  input  logic                    reset_n,

  // register write port
  input  logic                    reg_wr_i,
  input  acq_pkg::reg_addr_t      reg_addr_i,
  input  acq_pkg::reg_data_t      reg_wdata_i,

  // adc
  input  logic                    adc_measure_valid_i,
  output logic                    adc_reset_n_o,

  // analog switches
  output acq_pkg::azmux_t         azmux_o,
  output acq_pkg::pc_sw_t         pc_sw_o,

  // status side
  output acq_pkg::status_t        status_o,
  output logic                    led_o,
  output acq_pkg::monitor_t       monitor_o
);

  // active parameters
  acq_pkg::clk_count_t  precharge_count;
  acq_pkg::seq_idx_t    seq_n;
  acq_pkg::seq_entry_t  seq0;
  acq_pkg::seq_entry_t  seq1;
  acq_pkg::seq_entry_t  seq2;
  acq_pkg::seq_entry_t  seq3;

  // sequencer events
  logic                 seq_start;
  logic                 sample_done;
  acq_pkg::seq_idx_t    sample_done_idx;
  logic                 sample_last;

  //////////////////////////////////////////////////
  // input side
  acq_param_regs acq_param_regs_inst (
    .clk               (clk),
    .reset_n           (reset_n),
    .reg_wr_i          (reg_wr_i),
    .reg_addr_i        (reg_addr_i),
    .reg_wdata_i       (reg_wdata_i),
    .seq_start_i       (seq_start),
    .precharge_count_o (precharge_count),
    .seq_n_o           (seq_n),
    .seq0_o            (seq0),
    .seq1_o            (seq1),
    .seq2_o            (seq2),
    .seq3_o            (seq3)
  );

  //////////////////////////////////////////////////
  // sequencer
  sequence_acquisition sequence_acquisition_inst (
    .clk                 (clk),
    .reset_n             (reset_n),
    .precharge_count_i   (precharge_count),
    .seq_n_i             (seq_n),
    .seq0_i              (seq0),
    .seq1_i              (seq1),
    .seq2_i              (seq2),
    .seq3_i              (seq3),
    .adc_measure_valid_i (adc_measure_valid_i),
    .azmux_o             (azmux_o),
    .pc_sw_o             (pc_sw_o),
    .adc_reset_n_o       (adc_reset_n_o),
    .seq_start_o         (seq_start),
    .sample_done_o       (sample_done),
    .sample_done_idx_o   (sample_done_idx),
    .sample_last_o       (sample_last)
  );

  //////////////////////////////////////////////////
  // output side
  acq_status_monitor acq_status_monitor_inst (
    .clk                 (clk),
    .reset_n             (reset_n),
    .sample_done_i       (sample_done),
    .sample_done_idx_i   (sample_done_idx),
    .sample_last_i       (sample_last),
    .azmux_i             (azmux_o),
    .pc_sw_i             (pc_sw_o),
    .adc_reset_n_i       (adc_reset_n_o),
    .adc_measure_valid_i (adc_measure_valid_i),
    .status_o            (status_o),
    .led_o               (led_o),
    .monitor_o           (monitor_o)
  );

endmodule

/* hdl/sequence_acquisition.sv */
`timescale 1ns/1ns
`include "acq_cfg.svh"

module sequence_acquisition (
  input  logic                    clk,
  input  logic                    reset_n,

  // active parameters
  input  acq_pkg::clk_count_t     precharge_count_i,
  input  acq_pkg::seq_idx_t       seq_n_i,
  input  acq_pkg::seq_entry_t     seq0_i,
  input  acq_pkg::seq_entry_t     seq1_i,
  input  acq_pkg::seq_entry_t     seq2_i,
  input  acq_pkg::seq_entry_t     seq3_i,

  // level from the adc
  input  logic                    adc_measure_valid_i,

  // analog switch and adc control
  output acq_pkg::azmux_t         azmux_o,
  output acq_pkg::pc_sw_t         pc_sw_o,
  output logic                    adc_reset_n_o,

  // sequence events
  output logic                    seq_start_o,
  output logic                    sample_done_o,
  output acq_pkg::seq_idx_t       sample_done_idx_o,
  output logic                    sample_last_o
);

  acq_pkg::acq_state_t  state;
  acq_pkg::clk_count_t  count_down;
  acq_pkg::seq_idx_t    idx;
  acq_pkg::seq_idx_t    idx_next;
  acq_pkg::seq_entry_t  cur_entry;
  logic                 is_last;

  // entry for the current position
  always_comb
  begin
    case (idx)
      2'd0:    cur_entry = seq0_i;
      2'd1:    cur_entry = seq1_i;
      2'd2:    cur_entry = seq2_i;
      default: cur_entry = seq3_i;
    endcase
  end

  // wrap after seq_n (the last index in use)
  assign is_last  = (idx == seq_n_i);
  assign idx_next = is_last ? 2'd0 : idx + 2'd1;

  //////////////////////////////////////////////////
  // control state
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state         <= acq_pkg::ST_START;
      idx           <= 2'd0;
      azmux_o       <= `ACQ_S1;
      pc_sw_o       <= 2'b00;
      adc_reset_n_o <= 1'b0;
      seq_start_o   <= 1'b0;
      sample_done_o <= 1'b0;
    end
    else
    begin
      // single-cycle pulses by default
      seq_start_o   <= 1'b0;
      sample_done_o <= 1'b0;

      case (state)
        // one cycle with the adc held before the first sequence
        acq_pkg::ST_START:
        begin
          adc_reset_n_o <= 1'b0;
          state         <= acq_pkg::ST_BOOT;
          seq_start_o   <= 1'b1;
        end

        // pc switch to boot protects the signal from az charge injection
        acq_pkg::ST_BOOT:
        begin
          pc_sw_o <= 2'b00;
          state   <= acq_pkg::ST_BOOT_WAIT;
        end

        acq_pkg::ST_BOOT_WAIT:
          if (count_down == '0)
            state <= acq_pkg::ST_AZ_SEL;

        // azmux onto the entry's input (hi or a low)
        acq_pkg::ST_AZ_SEL:
        begin
          azmux_o <= cur_entry[3:0];
          state   <= acq_pkg::ST_AZ_WAIT;
        end

        acq_pkg::ST_AZ_WAIT:
          if (count_down == '0)
            state <= acq_pkg::ST_PC_SEL;

        // pc switch from boot to the signal (no-op for a value of 0)
        acq_pkg::ST_PC_SEL:
        begin
          pc_sw_o <= cur_entry[5:4];
          state   <= acq_pkg::ST_PC_WAIT;
        end

        // path has settled so the adc may run
        acq_pkg::ST_PC_WAIT:
          if (count_down == '0)
          begin
            adc_reset_n_o <= 1'b1;
            state         <= acq_pkg::ST_MEASURE;
          end

        // hold here until the adc reports however long it takes
        acq_pkg::ST_MEASURE:
          if (adc_measure_valid_i)
          begin
            adc_reset_n_o <= 1'b0;
            sample_done_o <= 1'b1;
            idx           <= idx_next;
            state         <= acq_pkg::ST_BOOT;
            // new sequence begins when we wrap
            seq_start_o   <= (idx_next == 2'd0);
          end

        default:
          state <= acq_pkg::ST_START;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // settle counter and sample payload
  always_ff @(posedge clk)
  begin
    case (state)
      acq_pkg::ST_BOOT, acq_pkg::ST_AZ_SEL, acq_pkg::ST_PC_SEL:
        count_down <= precharge_count_i;
      acq_pkg::ST_BOOT_WAIT, acq_pkg::ST_AZ_WAIT, acq_pkg::ST_PC_WAIT:
        count_down <= count_down - 24'd1;
      default:
        count_down <= count_down;
    endcase

    // index and last flag ride along with sample_done
    if (state == acq_pkg::ST_MEASURE && adc_measure_valid_i)
    begin
      sample_done_idx_o <= idx;
      sample_last_o     <= is_last;
    end
  end

endmodule

/* include/acq_cfg.svh */
`ifndef ACQ_CFG_SVH
`define ACQ_CFG_SVH

//////////////////////////////////////////////////
// azmux pin codes, enable bit in the msb
`define ACQ_S1 4'b1000
`define ACQ_S3 4'b1010
`define ACQ_S7 4'b1110
`define ACQ_S8 4'b1111

//////////////////////////////////////////////////
// register port addresses
`define ACQ_ADDR_PRECHARGE 3'd0
`define ACQ_ADDR_SEQ_N     3'd1
`define ACQ_ADDR_SEQ0      3'd2
`define ACQ_ADDR_SEQ1      3'd3
`define ACQ_ADDR_SEQ2      3'd4
`define ACQ_ADDR_SEQ3      3'd5

//////////////////////////////////////////////////
// values loaded at reset
`define ACQ_PRECHARGE_DEFAULT 24'd10
// entry layout is {pre-charge, azmux}
`define ACQ_SEQ0_DEFAULT {2'b01, `ACQ_S3}
`define ACQ_SEQ1_DEFAULT {2'b00, `ACQ_S7}
// seq_n is the last index, so 1 gives two entries
`define ACQ_SEQ_N_DEFAULT 2'd1

`endif

/* run_sim.sh */
#!/bin/sh
# build the acq_top testbench with verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f acq_top.f --top-module tb_acq_top \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_acq_top > sim.log 2>&1
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { cat sim.log; exit 1; }

/* testbench/acq_stimulus.txt */
// kind[31:28]: 1 write {addr[26:24], data[23:0]}, 2 expect {azmux[11:8], pc[5:4], status[2:0]}
// kind 3 stalls the adc for 60 cycles, kind f ends the list
// default sequence, S3/01 then S7/00
20000A10
20000E03
// precharge 4, seq_n 3, entries S8/10 S1/11 S3/00 S7/01
10000004
11000003
1200002F
13000038
1400000A
1500001E
20000F20
20000832
20000A04
20000E17
// second pass with a long adc stall on entry 0
20000F20
30000000
20000832
20000A04
20000E17
// write to an unused address, sequence must not change
1700003F
20000F20
20000832
20000A04
20000E17
F0000000

/* testbench/acq_top_chk.sv */
`timescale 1ns/1ns
`include "acq_cfg.svh"

module acq_top_chk (
  input  logic                    clk,
  input  logic                    reset_n,
  input  acq_pkg::azmux_t         azmux_i,
  input  acq_pkg::pc_sw_t         pc_sw_i,
  input  logic                    adc_reset_n_i,
  input  logic                    adc_measure_valid_i,
  input  logic                    sample_done_i,
  input  acq_pkg::status_t        status_i
);

  //////////////////////////////////////////////////
  // adc never runs with both switches still in their boot position
  adc_run_after_boot: assert property (@(posedge clk) disable iff (!reset_n)
    adc_reset_n_i |-> !(pc_sw_i == 2'b00 && azmux_i == `ACQ_S1))
    else $error("adc released while azmux and pre-charge are still at boot");

  // completion is a single-cycle pulse
  sample_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    sample_done_i |=> !sample_done_i)
    else $error("sample_done held for more than one cycle");

  // valid while measuring puts the adc back in reset on the next edge
  adc_reset_on_valid: assert property (@(posedge clk) disable iff (!reset_n)
    (adc_reset_n_i && adc_measure_valid_i) |=> !adc_reset_n_i)
    else $error("adc reset did not fall after measure valid");

  //////////////////////////////////////////////////
  // status word only moves right after a completion
  status_hold: assert property (@(posedge clk) disable iff (!reset_n)
    !sample_done_i |=> $stable(status_i))
    else $error("status changed without a completed sample");

endmodule

/* testbench/tb_acq_top.sv */
`timescale 1ns/1ns
`include "acq_cfg.svh"

module tb_acq_top;

  localparam int STIM_DEPTH = 64;
  localparam int WAIT_LIMIT = 2000;

  logic               clk;
  logic               reset_n;
  logic               reg_wr;
  acq_pkg::reg_addr_t reg_addr;
  acq_pkg::reg_data_t reg_wdata;
  logic               adc_valid;
  logic               adc_reset_n;
  acq_pkg::azmux_t    azmux;
  acq_pkg::pc_sw_t    pc_sw;
  acq_pkg::status_t   status;
  logic               led;
  acq_pkg::monitor_t  monitor;

  logic [31:0]        stim_mem [STIM_DEPTH];
  int                 seed;
  int                 samples_checked;
  logic               led_exp;
  logic               sample_open;
  acq_pkg::status_t   status_exp;
  // expected state of the sample in flight and of the last completed one
  acq_pkg::azmux_t    az_cur;
  acq_pkg::pc_sw_t    pc_cur;
  acq_pkg::status_t   status_done;

  tb_clock_gen clock_gen_inst (
    .clk_o     (clk),
    .reset_n_o (reset_n)
  );

  acq_top acq_top_inst (
    .clk                 (clk),
    .reset_n             (reset_n),
    .reg_wr_i            (reg_wr),
    .reg_addr_i          (reg_addr),
    .reg_wdata_i         (reg_wdata),
    .adc_measure_valid_i (adc_valid),
    .adc_reset_n_o       (adc_reset_n),
    .azmux_o             (azmux),
    .pc_sw_o             (pc_sw),
    .status_o            (status),
    .led_o               (led),
    .monitor_o           (monitor)
  );

  bind acq_top acq_top_chk acq_top_chk_inst (
    .clk                 (clk),
    .reset_n             (reset_n),
    .azmux_i             (azmux_o),
    .pc_sw_i             (pc_sw_o),
    .adc_reset_n_i       (adc_reset_n_o),
    .adc_measure_valid_i (adc_measure_valid_i),
    .sample_done_i       (sample_done),
    .status_i            (status_o)
  );

  //////////////////////////////////////////////////
  // error exit and typed compares
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_azmux(input string name, input acq_pkg::azmux_t got,
                             input acq_pkg::azmux_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_pc(input string name, input acq_pkg::pc_sw_t got,
                          input acq_pkg::pc_sw_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_status(input string name, input acq_pkg::status_t got,
                              input acq_pkg::status_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_monitor(input string name, input acq_pkg::monitor_t got,
                               input acq_pkg::monitor_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
  endtask

  // analyser vector as the decode rule defines it
  function automatic acq_pkg::monitor_t predict_monitor(input acq_pkg::azmux_t az,
    input acq_pkg::pc_sw_t pc, input logic run, input logic valid);
    acq_pkg::monitor_t m;
    m[0]   = (az == `ACQ_S3);
    m[1]   = (az == `ACQ_S7);
    m[2]   = (az == `ACQ_S1);
    m[3]   = (az == `ACQ_S8);
    m[5:4] = pc;
    m[6]   = run;
    m[7]   = valid;
    return m;
  endfunction

  //////////////////////////////////////////////////
  // bus and adc model
  task automatic wait_reset_release();
    int n;
    n = 0;
    while (reset_n !== 1'b1)
    begin
      @(posedge clk);
      #2;
      n++;
      if (n > WAIT_LIMIT)
        stop_on_error("reset was never released");
    end
  endtask

  // one write strobe driven 1 ns after the edge
  task automatic write_reg(input acq_pkg::reg_addr_t addr, input acq_pkg::reg_data_t data);
    @(posedge clk);
    #1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_wr    = 1'b0;
  endtask

  // wait for the adc release and check the selected entry
  task automatic check_run_start(input logic [31:0] word);
    acq_pkg::azmux_t az_exp;
    acq_pkg::pc_sw_t pc_exp;
    int              n;
    az_exp     = word[11:8];
    pc_exp     = word[5:4];
    status_exp = word[2:0];
    az_cur     = az_exp;
    pc_cur     = pc_exp;
    n = 0;
    while (adc_reset_n !== 1'b1)
    begin
      @(posedge clk);
      #2;
      n++;
      if (n > WAIT_LIMIT)
        stop_on_error("the ADC was never released from reset");
    end
    check_azmux("azmux_o", azmux, az_exp);
    check_pc("pc_sw_o", pc_sw, pc_exp);
    check_monitor("monitor_o", monitor, predict_monitor(az_exp, pc_exp, 1'b1, 1'b0));
    samples_checked++;
    sample_open = 1'b1;
  endtask

  // random adc conversion time and a one-cycle valid
  task automatic finish_sample();
    int delay;
    int n;
    delay = 3 + int'($unsigned($random(seed)) % 38);
    repeat (delay) @(posedge clk);
    #1;
    adc_valid = 1'b1;
    @(posedge clk);
    #1;
    adc_valid = 1'b0;
    n = 0;
    while (adc_reset_n !== 1'b0)
    begin
      @(posedge clk);
      #2;
      n++;
      if (n > WAIT_LIMIT)
        stop_on_error("the ADC was not put back into reset after valid");
    end
    // status lands one cycle after the fall
    @(posedge clk);
    #2;
    if (status_exp[0])
      led_exp = ~led_exp;
    check_status("status_o", status, status_exp);
    check_bit("led_o", led, led_exp);
    status_done = status_exp;
    sample_open = 1'b0;
  endtask

  // adc sits silent and every output holds its measuring value
  task automatic stall_adc();
    acq_pkg::monitor_t mon_exp;
    if (!sample_open)
      stop_on_error("an ADC stall was requested outside a measurement");
    mon_exp = predict_monitor(az_cur, pc_cur, 1'b1, 1'b0);
    repeat (60)
    begin
      @(posedge clk);
      #2;
      check_azmux("azmux_o", azmux, az_cur);
      check_pc("pc_sw_o", pc_sw, pc_cur);
      check_status("status_o", status, status_done);
      check_monitor("monitor_o", monitor, mon_exp);
      check_bit("led_o", led, led_exp);
      check_bit("adc_reset_n_o", adc_reset_n, 1'b1);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial
  begin
    int          line;
    logic [31:0] word;
    logic        done;
    seed            = 32'hf39b_df5a;
    samples_checked = 0;
    led_exp         = 1'b0;
    sample_open     = 1'b0;
    status_exp      = '0;
    az_cur          = `ACQ_S1;
    pc_cur          = 2'b00;
    status_done     = '0;
    reg_wr          = 1'b0;
    reg_addr        = '0;
    reg_wdata       = '0;
    adc_valid       = 1'b0;
    for (int i = 0; i < STIM_DEPTH; i++)
      stim_mem[i] = '0;
    $readmemh("testbench/acq_stimulus.txt", stim_mem);

    // state straight out of reset
    wait_reset_release();
    check_bit("adc_reset_n_o", adc_reset_n, 1'b0);
    check_status("status_o", status, 3'b000);
    check_bit("led_o", led, 1'b0);
    check_azmux("azmux_o", azmux, `ACQ_S1);
    check_pc("pc_sw_o", pc_sw, 2'b00);
    check_monitor("monitor_o", monitor, predict_monitor(`ACQ_S1, 2'b00, 1'b0, 1'b0));

    // writes land while the adc is busy with the previous entry
    line = 0;
    done = 1'b0;
    while (!done && line < STIM_DEPTH)
    begin
      word = stim_mem[line];
      case (word[31:28])
        4'h1:
          write_reg(word[26:24], word[23:0]);
        4'h2:
        begin
          if (sample_open)
            finish_sample();
          check_run_start(word);
        end
        4'h3:
          stall_adc();
        default:
          done = 1'b1;
      endcase
      line++;
    end
    if (sample_open)
      finish_sample();

    if (samples_checked == 0)
      stop_on_error("no samples were checked, the stimulus file is empty or missing");
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic reset_n_o
);

  // 10 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset low over the first 4 rising edges, released just after the 4th
  initial
  begin
    reset_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    reset_n_o = 1'b1;
  end

endmodule
